// ==== logic/mem_arb_params.svh ====
// ************************************************
// Memory arbiter parameters
// ************************************************

`ifndef MEM_ARB_PARAMS_SVH
`define MEM_ARB_PARAMS_SVH

// Clients sharing the single memory bank
`define MEM_NUM_CLIENTS  4

// Word address, data and tag widths
`define MEM_ADDR_W       8
`define MEM_DATA_W       32
`define MEM_CLIENT_TAG_W 4
`define MEM_SEL_W        2
`define MEM_BUS_TAG_W    (`MEM_CLIENT_TAG_W + `MEM_SEL_W)

// Number of words in the bank
`define MEM_DEPTH        (1 << `MEM_ADDR_W)

`endif

// ==== logic/mem_arb_pkg.sv ====
// ************************************************
// Memory arbiter types
// ************************************************

`include "mem_arb_params.svh"

package mem_arb_pkg;

    // Word address into the bank
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [`MEM_DATA_W-1:0] data_t;

    // One enable bit per data byte
    typedef logic [`MEM_DATA_W/8-1:0] byteen_t;

    // Tag as seen by a client
    typedef logic [`MEM_CLIENT_TAG_W-1:0] client_tag_t;

    // Tag on the bank side, client tag above the client index
    typedef logic [`MEM_BUS_TAG_W-1:0] bus_tag_t;

    // Client index
    typedef logic [`MEM_SEL_W-1:0] client_sel_t;

endpackage

// ==== logic/stream_arb.sv ====
// ************************************************
// Round-robin stream arbiter
// ************************************************

`timescale 1ns/1ps

module stream_arb #(
    parameter int NUM_INPUTS = 4,
    parameter int DATAW      = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_INPUTS-1:0]            valid_in,
    output logic [NUM_INPUTS-1:0]            ready_in,
    input  logic [NUM_INPUTS-1:0][DATAW-1:0] data_in,
    output logic                             valid_out,
    input  logic                             ready_out,
    output logic [DATAW-1:0]                 data_out,
    output mem_arb_pkg::client_sel_t         sel_out
);
    mem_arb_pkg::client_sel_t rr_ptr;
    mem_arb_pkg::client_sel_t grant_idx;
    logic                     grant_any;
    logic                     accept;

    // The output register can take a new entry when empty or being drained
    assign accept = !valid_out || ready_out;

    // Search starts one past the last grant and wraps around
    always_comb begin
        int idx;
        grant_idx = rr_ptr;
        grant_any = 1'b0;
        for (int k = 1; k <= NUM_INPUTS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_INPUTS;
            if (!grant_any && valid_in[idx]) begin
                grant_idx = mem_arb_pkg::client_sel_t'(idx);
                grant_any = 1'b1;
            end
        end
    end

    // Idle inputs see ready so that ready only drops for losers or a full register
    always_comb begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            ready_in[i] = accept && (!valid_in[i] || grant_idx == mem_arb_pkg::client_sel_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            rr_ptr    <= mem_arb_pkg::client_sel_t'(NUM_INPUTS - 1);
        end else if (accept) begin
            valid_out <= grant_any;
            if (grant_any) begin
                rr_ptr <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && grant_any) begin
            data_out <= data_in[grant_idx];
            sel_out  <= grant_idx;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ready_in & valid_in))
        else $error("stream_arb: more than one input granted");

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !ready_out |=> valid_out && $stable(data_out) && $stable(sel_out))
        else $error("stream_arb: output changed while stalled");

endmodule

// ==== logic/stream_switch.sv ====
// ************************************************
// Stream demultiplexer
// ************************************************

`timescale 1ns/1ps

module stream_switch #(
    parameter int NUM_OUTPUTS = 4,
    parameter int DATAW       = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  mem_arb_pkg::client_sel_t          sel_in,
    input  logic                              valid_in,
    output logic                              ready_in,
    input  logic [DATAW-1:0]                  data_in,
    output logic [NUM_OUTPUTS-1:0]            valid_out,
    input  logic [NUM_OUTPUTS-1:0]            ready_out,
    output logic [NUM_OUTPUTS-1:0][DATAW-1:0] data_out
);
    // Only the selected output sees valid, and its ready goes back upstream
    always_comb begin
        valid_out = '0;
        ready_in  = 1'b0;
        for (int i = 0; i < NUM_OUTPUTS; i++) begin
            if (int'(sel_in) == i) begin
                valid_out[i] = valid_in;
                ready_in     = ready_out[i];
            end
        end
    end

    // Data is shared by all outputs
    assign data_out = {NUM_OUTPUTS{data_in}};

    // A select past the last output would drop the response
    a_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
        valid_in |-> int'(sel_in) < NUM_OUTPUTS)
        else $error("stream_switch: select out of range");

endmodule

// ==== logic/mem_arb.sv ====
// ************************************************
// Memory request arbiter
// ************************************************

`timescale 1ns/1ps

`include "mem_arb_params.svh"

module mem_arb (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [`MEM_NUM_CLIENTS-1:0]                       req_valid,
    output logic [`MEM_NUM_CLIENTS-1:0]                       req_ready,
    input  logic [`MEM_NUM_CLIENTS-1:0]                       req_rw,
    input  mem_arb_pkg::byteen_t [`MEM_NUM_CLIENTS-1:0]       req_byteen,
    input  mem_arb_pkg::addr_t [`MEM_NUM_CLIENTS-1:0]         req_addr,
    input  mem_arb_pkg::data_t [`MEM_NUM_CLIENTS-1:0]         req_data,
    input  mem_arb_pkg::client_tag_t [`MEM_NUM_CLIENTS-1:0]   req_tag,
    output logic [`MEM_NUM_CLIENTS-1:0]                       rsp_valid,
    input  logic [`MEM_NUM_CLIENTS-1:0]                       rsp_ready,
    output mem_arb_pkg::data_t [`MEM_NUM_CLIENTS-1:0]         rsp_data,
    output mem_arb_pkg::client_tag_t [`MEM_NUM_CLIENTS-1:0]   rsp_tag,
    output logic                                              mem_req_valid,
    input  logic                                              mem_req_ready,
    output logic                                              mem_req_rw,
    output mem_arb_pkg::byteen_t                              mem_req_byteen,
    output mem_arb_pkg::addr_t                                mem_req_addr,
    output mem_arb_pkg::data_t                                mem_req_data,
    output mem_arb_pkg::bus_tag_t                             mem_req_tag,
    input  logic                                              mem_rsp_valid,
    output logic                                              mem_rsp_ready,
    input  mem_arb_pkg::data_t                                mem_rsp_data,
    input  mem_arb_pkg::bus_tag_t                             mem_rsp_tag
);
    localparam int N         = `MEM_NUM_CLIENTS;
    localparam int SEL_W     = $bits(mem_arb_pkg::client_sel_t);
    localparam int BUS_TAG_W = $bits(mem_arb_pkg::bus_tag_t);
    localparam int REQ_DATAW = 1 + $bits(mem_arb_pkg::byteen_t) + $bits(mem_arb_pkg::addr_t)
                             + $bits(mem_arb_pkg::data_t) + $bits(mem_arb_pkg::client_tag_t);
    localparam int RSP_DATAW = $bits(mem_arb_pkg::client_tag_t) + $bits(mem_arb_pkg::data_t);

    logic [N-1:0][REQ_DATAW-1:0] req_packed;
    logic [REQ_DATAW-1:0]        arb_data;
    mem_arb_pkg::client_sel_t    arb_sel;
    mem_arb_pkg::client_tag_t    arb_tag;
    mem_arb_pkg::client_sel_t    rsp_sel;
    logic [RSP_DATAW-1:0]        rsp_payload;
    logic [N-1:0][RSP_DATAW-1:0] rsp_packed;

    for (genvar i = 0; i < N; i++) begin : g_req_pack
        assign req_packed[i] = {req_rw[i], req_byteen[i], req_addr[i], req_data[i], req_tag[i]};
    end

    stream_arb #(
        .NUM_INPUTS (N),
        .DATAW      (REQ_DATAW)
    ) u_req_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (req_valid),
        .ready_in  (req_ready),
        .data_in   (req_packed),
        .valid_out (mem_req_valid),
        .ready_out (mem_req_ready),
        .data_out  (arb_data),
        .sel_out   (arb_sel)
    );

    assign {mem_req_rw, mem_req_byteen, mem_req_addr, mem_req_data, arb_tag} = arb_data;

    // Winning client index goes in the low tag bits
    assign mem_req_tag = {arb_tag, arb_sel};

    // The low tag bits route the response, the rest is the client's own tag
    assign rsp_sel     = mem_rsp_tag[SEL_W-1:0];
    assign rsp_payload = {mem_rsp_tag[BUS_TAG_W-1:SEL_W], mem_rsp_data};

    stream_switch #(
        .NUM_OUTPUTS (N),
        .DATAW       (RSP_DATAW)
    ) u_rsp_switch (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel_in    (rsp_sel),
        .valid_in  (mem_rsp_valid),
        .ready_in  (mem_rsp_ready),
        .data_in   (rsp_payload),
        .valid_out (rsp_valid),
        .ready_out (rsp_ready),
        .data_out  (rsp_packed)
    );

    for (genvar i = 0; i < N; i++) begin : g_rsp_unpack
        assign {rsp_tag[i], rsp_data[i]} = rsp_packed[i];
    end

endmodule

// ==== logic/mem_bank.sv ====
// ************************************************
// Single-port memory bank
// ************************************************

`timescale 1ns/1ps

`include "mem_arb_params.svh"

module mem_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_rw,
    input  mem_arb_pkg::byteen_t  req_byteen,
    input  mem_arb_pkg::addr_t    req_addr,
    input  mem_arb_pkg::data_t    req_data,
    input  mem_arb_pkg::bus_tag_t req_tag,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output mem_arb_pkg::data_t    rsp_data,
    output mem_arb_pkg::bus_tag_t rsp_tag
);
    localparam int NUM_BYTES = $bits(mem_arb_pkg::byteen_t);

    mem_arb_pkg::data_t mem [`MEM_DEPTH];
    logic               wr_fire;
    logic               rd_fire;

    // Stall only when a read response is still waiting to be taken
    assign req_ready = !rsp_valid || rsp_ready;

    // rw high means write
    assign wr_fire = req_valid && req_ready && req_rw;
    assign rd_fire = req_valid && req_ready && !req_rw;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (req_byteen[b]) begin
                    mem[req_addr][b*8 +: 8] <= req_data[b*8 +: 8];
                end
            end
        end
    end

    // A new read may refill the register in the cycle the old response leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_data <= mem[req_addr];
            rsp_tag  <= req_tag;
        end
    end

    a_no_read_when_held: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |-> !(req_valid && req_ready && !req_rw))
        else $error("mem_bank: read accepted over a held response");

endmodule

// ==== logic/mem_subsys_top.sv ====
// ************************************************
// Memory subsystem top
// ************************************************

`timescale 1ns/1ps

`include "mem_arb_params.svh"

module mem_subsys_top (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [`MEM_NUM_CLIENTS-1:0]                     req_valid,
    output logic [`MEM_NUM_CLIENTS-1:0]                     req_ready,
    input  logic [`MEM_NUM_CLIENTS-1:0]                     req_rw,
    input  mem_arb_pkg::byteen_t [`MEM_NUM_CLIENTS-1:0]     req_byteen,
    input  mem_arb_pkg::addr_t [`MEM_NUM_CLIENTS-1:0]       req_addr,
    input  mem_arb_pkg::data_t [`MEM_NUM_CLIENTS-1:0]       req_data,
    input  mem_arb_pkg::client_tag_t [`MEM_NUM_CLIENTS-1:0] req_tag,
    output logic [`MEM_NUM_CLIENTS-1:0]                     rsp_valid,
    input  logic [`MEM_NUM_CLIENTS-1:0]                     rsp_ready,
    output mem_arb_pkg::data_t [`MEM_NUM_CLIENTS-1:0]       rsp_data,
    output mem_arb_pkg::client_tag_t [`MEM_NUM_CLIENTS-1:0] rsp_tag
);
    // Bank-side request and response channels
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    logic                  mem_req_rw;
    mem_arb_pkg::byteen_t  mem_req_byteen;
    mem_arb_pkg::addr_t    mem_req_addr;
    mem_arb_pkg::data_t    mem_req_data;
    mem_arb_pkg::bus_tag_t mem_req_tag;
    logic                  mem_rsp_valid;
    logic                  mem_rsp_ready;
    mem_arb_pkg::data_t    mem_rsp_data;
    mem_arb_pkg::bus_tag_t mem_rsp_tag;

    mem_arb u_mem_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_rw         (req_rw),
        .req_byteen     (req_byteen),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .req_tag        (req_tag),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp_data       (rsp_data),
        .rsp_tag        (rsp_tag),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_rw     (mem_req_rw),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_tag    (mem_req_tag),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_tag    (mem_rsp_tag)
    );

    mem_bank u_mem_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (mem_req_valid),
        .req_ready  (mem_req_ready),
        .req_rw     (mem_req_rw),
        .req_byteen (mem_req_byteen),
        .req_addr   (mem_req_addr),
        .req_data   (mem_req_data),
        .req_tag    (mem_req_tag),
        .rsp_valid  (mem_rsp_valid),
        .rsp_ready  (mem_rsp_ready),
        .rsp_data   (mem_rsp_data),
        .rsp_tag    (mem_rsp_tag)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
// ************************************************
// Testbench clock
// ************************************************

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD = 4.0
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0);
            clk = ~clk;
        end
    end

endmodule

// ==== tests/tb_mem_subsys.sv ====
// ************************************************
// Memory subsystem testbench
// ************************************************

`timescale 1ns/1ps

`include "mem_arb_params.svh"

module tb_mem_subsys;
    localparam int N            = `MEM_NUM_CLIENTS;
    localparam int TIMEOUT      = 50;
    localparam int RAND_REQS    = 400;
    localparam int RAND_TIMEOUT = 20000;
    localparam int QDEPTH       = 1024;

    logic                                clk;
    logic                                rst_n;
    logic [N-1:0]                        req_valid;
    logic [N-1:0]                        req_ready;
    logic [N-1:0]                        req_rw;
    mem_arb_pkg::byteen_t [N-1:0]        req_byteen;
    mem_arb_pkg::addr_t [N-1:0]          req_addr;
    mem_arb_pkg::data_t [N-1:0]          req_data;
    mem_arb_pkg::client_tag_t [N-1:0]    req_tag;
    logic [N-1:0]                        rsp_valid;
    logic [N-1:0]                        rsp_ready;
    mem_arb_pkg::data_t [N-1:0]          rsp_data;
    mem_arb_pkg::client_tag_t [N-1:0]    rsp_tag;

    // Reference memory and per-client FIFOs of expected read responses
    mem_arb_pkg::data_t       ref_mem [`MEM_DEPTH];
    mem_arb_pkg::data_t       exp_data [N][QDEPTH];
    mem_arb_pkg::client_tag_t exp_tag [N][QDEPTH];
    int                       exp_wr [N];
    int                       exp_rd [N];

    // Handshakes that complete at the coming rising edge
    logic [N-1:0] accepted;
    logic [N-1:0] rsp_seen;
    integer       seed;
    string        test_name;
    int           test_errors;
    int           tests_run;
    int           tests_failed;

    tb_clk_gen #(.PERIOD(4.0)) u_clk_gen (.clk(clk));

    mem_subsys_top u_mem_subsys_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_rw     (req_rw),
        .req_byteen (req_byteen),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .req_tag    (req_tag),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_tag    (rsp_tag)
    );

    function automatic mem_arb_pkg::data_t merge_bytes(input mem_arb_pkg::data_t old_word,
            input mem_arb_pkg::data_t new_word, input mem_arb_pkg::byteen_t be);
        mem_arb_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < $bits(be); b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic bit pending_responses();
        for (int c = 0; c < N; c++) begin
            if (exp_rd[c] != exp_wr[c]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic report_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // Inputs are stable a little after the falling edge, so the handshakes
    // seen here are the ones the next rising edge will complete
    task automatic observe_cycle();
        int slot;
        #1;
        accepted = req_valid & req_ready;
        rsp_seen = rsp_valid & rsp_ready;
        for (int c = 0; c < N; c++) begin
            // Responses first, since a read accepted now cannot answer in this cycle
            if (rsp_seen[c]) begin
                assert (exp_rd[c] != exp_wr[c]) else begin
                    report_error($sformatf("client %0d got a response it never asked for", c));
                end
                if (exp_rd[c] != exp_wr[c]) begin
                    slot = exp_rd[c] % QDEPTH;
                    check_equal($sformatf("client %0d data", c), exp_data[c][slot], rsp_data[c]);
                    check_equal($sformatf("client %0d tag", c), exp_tag[c][slot], rsp_tag[c]);
                    exp_rd[c]++;
                end
            end
            if (accepted[c] && req_rw[c]) begin
                ref_mem[req_addr[c]] = merge_bytes(ref_mem[req_addr[c]], req_data[c],
                                                   req_byteen[c]);
            end else if (accepted[c]) begin
                slot = exp_wr[c] % QDEPTH;
                exp_data[c][slot] = ref_mem[req_addr[c]];
                exp_tag[c][slot]  = req_tag[c];
                exp_wr[c]++;
            end
        end
    endtask

    task automatic send_request(input int c, input logic rw, input mem_arb_pkg::byteen_t be,
            input mem_arb_pkg::addr_t addr, input mem_arb_pkg::data_t data,
            input mem_arb_pkg::client_tag_t tag);
        int n;
        @(negedge clk);
        req_valid[c]  = 1'b1;
        req_rw[c]     = rw;
        req_byteen[c] = be;
        req_addr[c]   = addr;
        req_data[c]   = data;
        req_tag[c]    = tag;
        observe_cycle();
        n = 0;
        while (!accepted[c] && n < TIMEOUT) begin
            @(negedge clk);
            observe_cycle();
            n++;
        end
        assert (accepted[c]) else begin
            report_error($sformatf("request from client %0d was never accepted", c));
        end
        @(negedge clk);
        req_valid[c] = 1'b0;
        observe_cycle();
    endtask

    task automatic wait_response(input int c, output int cycles);
        @(negedge clk);
        observe_cycle();
        cycles = 1;
        while (!rsp_seen[c] && cycles < TIMEOUT) begin
            @(negedge clk);
            observe_cycle();
            cycles++;
        end
        assert (rsp_seen[c]) else begin
            report_error($sformatf("client %0d never received its read response", c));
        end
    endtask

    task automatic load_random_request(input int c, input bit write_only);
        logic [31:0] r;
        r = $random(seed);
        req_valid[c]  = 1'b1;
        req_rw[c]     = write_only ? 1'b1 : r[0];
        req_byteen[c] = r[7:4];
        // A 32-word window keeps reads hitting recently written words
        req_addr[c]   = {3'b000, r[12:8]};
        req_tag[c]    = r[19:16];
        req_data[c]   = $random(seed);
    endtask

    initial begin
        int                   lat;
        int                   c;
        int                   grants [16];
        int                   n_grants;
        int                   cycles;
        int                   issued;
        logic [N-1:0]         mask;
        logic [31:0]          r;
        mem_arb_pkg::addr_t   a;
        mem_arb_pkg::data_t   d;
        mem_arb_pkg::byteen_t be;

        seed         = 40;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        req_valid    = '0;
        req_rw       = '0;
        req_byteen   = '0;
        req_addr     = '0;
        req_data     = '0;
        req_tag      = '0;
        rsp_ready    = '1;
        accepted     = '0;
        rsp_seen     = '0;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < N; i++) begin
            exp_wr[i] = 0;
            exp_rd[i] = 0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_state");
        observe_cycle();
        check_equal("rsp_valid", '0, rsp_valid);
        check_equal("req_ready", {N{1'b1}}, req_ready);
        finish_test();

        start_test("write_read");
        a = $random(seed);
        d = $random(seed);
        send_request(2, 1'b1, 4'hF, a, d, 4'h5);
        send_request(2, 1'b0, 4'h0, a, '0, 4'h9);
        wait_response(2, lat);
        // The cycle after the transfer is spent inside send_request
        check_equal("read latency", 2, lat + 1);
        finish_test();

        start_test("byte_enables");
        r  = $random(seed);
        c  = r[1:0];
        a  = r[15:8];
        be = r[19:16];
        if (be == 4'h0 || be == 4'hF) begin
            be = 4'b0110;
        end
        send_request(c, 1'b1, 4'hF, a, $random(seed), r[23:20]);
        send_request(c, 1'b1, be, a, $random(seed), r[27:24]);
        send_request(c, 1'b0, 4'h0, a, '0, r[31:28]);
        wait_response(c, lat);
        finish_test();

        start_test("round_robin");
        n_grants = 0;
        cycles   = 0;
        @(negedge clk);
        for (int k = 0; k < N; k++) begin
            load_random_request(k, 1'b1);
        end
        observe_cycle();
        while (n_grants < 16 && cycles < TIMEOUT) begin
            for (int k = 0; k < N; k++) begin
                if (accepted[k] && n_grants < 16) begin
                    grants[n_grants] = k;
                    n_grants++;
                end
            end
            @(negedge clk);
            for (int k = 0; k < N; k++) begin
                if (accepted[k]) begin
                    load_random_request(k, 1'b1);
                end
            end
            observe_cycle();
            cycles++;
        end
        // Let the requests still waiting go through before dropping valid
        while (req_valid != '0 && cycles < TIMEOUT) begin
            @(negedge clk);
            req_valid = req_valid & ~accepted;
            observe_cycle();
            cycles++;
        end
        assert (n_grants == 16 && req_valid == '0) else begin
            report_error("requests with all clients active were not all accepted in time");
        end
        for (int w = 0; w + N <= n_grants; w++) begin
            mask = '0;
            for (int j = 0; j < N; j++) begin
                mask[grants[w + j]] = 1'b1;
            end
            check_equal($sformatf("clients in window %0d", w), {N{1'b1}}, mask);
        end
        finish_test();

        start_test("random_traffic");
        issued = 0;
        cycles = 0;
        while (cycles < RAND_TIMEOUT &&
               (issued < RAND_REQS || req_valid != '0 || pending_responses())) begin
            @(negedge clk);
            for (int k = 0; k < N; k++) begin
                if (accepted[k]) begin
                    req_valid[k] = 1'b0;
                end
                r = $random(seed);
                if (!req_valid[k] && issued < RAND_REQS && r[1:0] != 2'b00) begin
                    load_random_request(k, 1'b0);
                    issued++;
                end
            end
            r = $random(seed);
            rsp_ready = r[3:0] | r[7:4];
            observe_cycle();
            cycles++;
        end
        assert (issued == RAND_REQS && req_valid == '0 && !pending_responses()) else begin
            report_error("random traffic did not finish, responses are missing or stuck");
        end
        finish_test();

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/mem_arb_pkg.sv
logic/stream_arb.sv
logic/stream_switch.sv
logic/mem_arb.sv
logic/mem_bank.sv
logic/mem_subsys_top.sv
tests/tb_clk_gen.sv
tests/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

export_include_dirs:
  - logic

sources:
  - logic/mem_arb_pkg.sv
  - logic/stream_arb.sv
  - logic/stream_switch.sv
  - logic/mem_arb.sv
  - logic/mem_bank.sv
  - logic/mem_subsys_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_mem_subsys.sv
